// File: hw/backend_pkg.sv
package backend_pkg;

	localparam int NUM_REGS    = 32;
	localparam int NUM_FWD_SRC = 3;

	// bit positions in fwd_sel_t
	localparam int FWD_M1 = 0;
	localparam int FWD_M2 = 1;
	localparam int FWD_WB = 2;

	// bit positions in stall_vec_t
	localparam int STG_EX = 0;
	localparam int STG_M1 = 1;
	localparam int STG_M2 = 2;

	typedef logic [31:0]            word_t;
	typedef logic [4:0]             reg_idx_t;
	typedef logic [11:0]            imm12_t;
	typedef logic [NUM_FWD_SRC-1:0] fwd_sel_t;   // all zero selects the held operand
	typedef logic [2:0]             stall_vec_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LU12I
	} alu_op_e;

	typedef struct packed {
		alu_op_e  alu_op;
		reg_idx_t rd;
		reg_idx_t rj;
		reg_idx_t rk;
		imm12_t   imm;
		logic     use_imm;   // imm replaces the rk value
	} inst_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		alu_op_e  alu_op;
		logic     use_imm;
		fwd_sel_t fwd_j;     // only meaningful in EX
		fwd_sel_t fwd_k;
	} stage_ctrl_t;

	typedef struct packed {
		word_t opnd_j;
		word_t opnd_k;
		word_t result;
	} stage_data_t;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/10ps

module reg_file import backend_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rd_addr_j_i,
	input  reg_idx_t rd_addr_k_i,
	output word_t    rd_data_j_o,
	output word_t    rd_data_k_o,
	input  logic     wr_en_i,
	input  reg_idx_t wr_addr_i,
	input  word_t    wr_data_i
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// r0 is hardwired, a same-cycle write bypasses the array
	assign rd_data_j_o = (rd_addr_j_i == '0) ? '0 :
		(wr_en_i && wr_addr_i == rd_addr_j_i) ? wr_data_i :
		regs[rd_addr_j_i];

	assign rd_data_k_o = (rd_addr_k_i == '0) ? '0 :
		(wr_en_i && wr_addr_i == rd_addr_k_i) ? wr_data_i :
		regs[rd_addr_k_i];

endmodule

// File: hw/hazard_fwd.sv
`timescale 1ns/10ps

module hazard_fwd import backend_pkg::*; (
	input  inst_t       issue_inst_i,
	input  stage_ctrl_t ex_ctrl_i,
	input  stage_ctrl_t m1_ctrl_i,
	input  stage_ctrl_t m2_ctrl_i,
	output fwd_sel_t    fwd_j_o,
	output fwd_sel_t    fwd_k_o
);

	// does this stage hold the producer of src
	function automatic logic produces(stage_ctrl_t ctrl, reg_idx_t src);
		return ctrl.valid && (ctrl.rd == src) && (src != '0);
	endfunction

	// newest producer wins; each stage is one step further by the time EX reads it
	function automatic fwd_sel_t pick(
		reg_idx_t    src,
		stage_ctrl_t ex,
		stage_ctrl_t m1,
		stage_ctrl_t m2
	);
		fwd_sel_t sel;
		sel = '0;
		if (produces(ex, src)) begin
			sel[FWD_M1] = 1'b1;
		end else if (produces(m1, src)) begin
			sel[FWD_M2] = 1'b1;
		end else if (produces(m2, src)) begin
			sel[FWD_WB] = 1'b1;
		end
		// anything older is already in the regfile or its write-through
		return sel;
	endfunction

	assign fwd_j_o = pick(issue_inst_i.rj, ex_ctrl_i, m1_ctrl_i, m2_ctrl_i);

	// no rk read when the immediate is used
	assign fwd_k_o = issue_inst_i.use_imm ? '0 :
		pick(issue_inst_i.rk, ex_ctrl_i, m1_ctrl_i, m2_ctrl_i);

endmodule

// File: hw/forward_mux.sv
`timescale 1ns/10ps

module forward_mux import backend_pkg::*; #(
	parameter int SRC_NUM = 3
) (
	input  logic [SRC_NUM-1:0]  sel_i,
	input  word_t [SRC_NUM-1:0] src_i,
	input  word_t               held_i,
	output word_t               data_o
);

	word_t picked;

	// one-hot and-or select
	always_comb begin
		picked = '0;
		for (int i = 0; i < SRC_NUM; i++) begin
			picked |= src_i[i] & {$bits(word_t){sel_i[i]}};
		end
	end

	assign data_o = (|sel_i) ? picked : held_i;   // no hit means the held value

endmodule

// File: hw/stage_regs.sv
`timescale 1ns/10ps

module stage_regs import backend_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  stall_vec_t  stage_hold_i,
	input  logic        issue_fire_i,
	input  inst_t       issue_inst_i,
	input  fwd_sel_t    issue_fwd_j_i,
	input  fwd_sel_t    issue_fwd_k_i,
	input  word_t       issue_opnd_j_i,
	input  word_t       issue_opnd_k_i,
	input  word_t       ex_fwd_j_i,
	input  word_t       ex_fwd_k_i,
	input  word_t       ex_result_i,
	output logic        issue_ready_o,
	output stage_ctrl_t ex_ctrl_o,
	output stage_ctrl_t m1_ctrl_o,
	output stage_ctrl_t m2_ctrl_o,
	output stage_ctrl_t wb_ctrl_o,
	output stage_data_t ex_data_o,
	output word_t       m1_result_o,
	output word_t       m2_result_o,
	output word_t       wb_result_o
);

	stall_vec_t  stall;
	stage_ctrl_t ex_ctrl;
	stage_ctrl_t m1_ctrl;
	stage_ctrl_t m2_ctrl;
	stage_ctrl_t wb_ctrl;
	word_t       ex_opnd_j;
	word_t       ex_opnd_k;
	word_t       m1_result;
	word_t       m2_result;
	word_t       wb_result;

	// a hold also stalls everything in front of it
	assign stall[STG_M2] = stage_hold_i[STG_M2];
	assign stall[STG_M1] = stage_hold_i[STG_M1] | stall[STG_M2];
	assign stall[STG_EX] = stage_hold_i[STG_EX] | stall[STG_M1];

	assign issue_ready_o = ~stall[STG_EX];

	// follow the producer while EX waits
	function automatic fwd_sel_t reaim(fwd_sel_t sel, stall_vec_t stl);
		fwd_sel_t nxt;
		nxt[FWD_M1] = sel[FWD_M1] & stl[STG_M1];
		nxt[FWD_M2] = (sel[FWD_M1] & ~stl[STG_M1]) | (sel[FWD_M2] & stl[STG_M2]);
		nxt[FWD_WB] = sel[FWD_M2] & ~stl[STG_M2];
		// a WB pick is already captured into the held operand
		return nxt;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
		end else if (!stall[STG_EX]) begin
			if (issue_fire_i) begin
				ex_ctrl.valid   <= 1'b1;
				ex_ctrl.rd      <= issue_inst_i.rd;
				ex_ctrl.alu_op  <= issue_inst_i.alu_op;
				ex_ctrl.use_imm <= issue_inst_i.use_imm;
				ex_ctrl.fwd_j   <= issue_fwd_j_i;
				ex_ctrl.fwd_k   <= issue_fwd_k_i;
			end else begin
				ex_ctrl.valid <= 1'b0;   // nothing issued
			end
		end else begin
			ex_ctrl.fwd_j <= reaim(ex_ctrl.fwd_j, stall);
			ex_ctrl.fwd_k <= reaim(ex_ctrl.fwd_k, stall);
		end
	end

	always_ff @(posedge clk) begin
		if (stall[STG_EX]) begin
			// keep whatever the muxes picked up this cycle
			ex_opnd_j <= ex_fwd_j_i;
			ex_opnd_k <= ex_fwd_k_i;
		end else if (issue_fire_i) begin
			ex_opnd_j <= issue_opnd_j_i;
			// raw immediate rides in the k slot, alu sign-extends it
			ex_opnd_k <= issue_inst_i.use_imm ? word_t'(issue_inst_i.imm) : issue_opnd_k_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_ctrl <= '0;
		end else if (!stall[STG_M1]) begin
			m1_ctrl       <= ex_ctrl;
			m1_ctrl.valid <= ex_ctrl.valid & ~stall[STG_EX];   // bubble behind stalled EX
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m2_ctrl <= '0;
		end else if (!stall[STG_M2]) begin
			m2_ctrl       <= m1_ctrl;
			m2_ctrl.valid <= m1_ctrl.valid & ~stall[STG_M1];
		end
	end

	// WB never stalls
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ctrl <= '0;
		end else begin
			wb_ctrl       <= m2_ctrl;
			wb_ctrl.valid <= m2_ctrl.valid & ~stall[STG_M2] & (m2_ctrl.rd != '0);
		end
	end

	// results just travel, all of them exist at end of EX
	always_ff @(posedge clk) begin
		if (!stall[STG_M1]) begin
			m1_result <= ex_result_i;
		end
		if (!stall[STG_M2]) begin
			m2_result <= m1_result;
		end
		wb_result <= m2_result;
	end

	assign ex_ctrl_o = ex_ctrl;
	assign m1_ctrl_o = m1_ctrl;
	assign m2_ctrl_o = m2_ctrl;
	assign wb_ctrl_o = wb_ctrl;

	assign ex_data_o = '{opnd_j: ex_opnd_j, opnd_k: ex_opnd_k, result: ex_result_i};

	assign m1_result_o = m1_result;
	assign m2_result_o = m2_result;
	assign wb_result_o = wb_result;

endmodule

// File: hw/alu.sv
`timescale 1ns/10ps

module alu import backend_pkg::*; (
	input  alu_op_e op_i,
	input  word_t   opnd_j_i,
	input  word_t   opnd_k_i,
	input  logic    use_imm_i,
	input  imm12_t  imm_i,
	output word_t   result_o
);

	word_t      imm_ext;
	word_t      opnd_b;
	logic [4:0] shamt;

	assign imm_ext = {{20{imm_i[11]}}, imm_i};
	assign opnd_b  = use_imm_i ? imm_ext : opnd_k_i;
	assign shamt   = opnd_b[4:0];   // only the low five bits shift

	always_comb begin
		case (op_i)
			ALU_ADD: begin
				result_o = opnd_j_i + opnd_b;
			end
			ALU_SUB: begin
				result_o = opnd_j_i - opnd_b;
			end
			ALU_AND: begin
				result_o = opnd_j_i & opnd_b;
			end
			ALU_OR: begin
				result_o = opnd_j_i | opnd_b;
			end
			ALU_XOR: begin
				result_o = opnd_j_i ^ opnd_b;
			end
			ALU_SLT: begin
				result_o = word_t'($signed(opnd_j_i) < $signed(opnd_b));
			end
			ALU_SLTU: begin
				result_o = word_t'(opnd_j_i < opnd_b);
			end
			ALU_SLL: begin
				result_o = opnd_j_i << shamt;
			end
			ALU_SRL: begin
				result_o = opnd_j_i >> shamt;
			end
			ALU_SRA: begin
				result_o = word_t'($signed(opnd_j_i) >>> shamt);
			end
			ALU_LU12I: begin
				result_o = {imm_i, 20'b0};   // upper immediate, rj ignored
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// File: hw/backend_pipeline.sv
`timescale 1ns/10ps

module backend_pipeline import backend_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       issue_valid_i,
	input  inst_t      issue_inst_i,
	output logic       issue_ready_o,
	input  stall_vec_t stage_hold_i,
	output logic       reg_w_valid_o,
	output reg_idx_t   reg_w_addr_o,
	output word_t      reg_w_data_o
);

	logic                    issue_fire;
	word_t                   rf_data_j;
	word_t                   rf_data_k;
	fwd_sel_t                issue_fwd_j;
	fwd_sel_t                issue_fwd_k;
	stage_ctrl_t             ex_ctrl;
	stage_ctrl_t             m1_ctrl;
	stage_ctrl_t             m2_ctrl;
	stage_ctrl_t             wb_ctrl;
	stage_data_t             ex_data;
	word_t                   m1_result;
	word_t                   m2_result;
	word_t                   wb_result;
	word_t                   fwd_opnd_j;
	word_t                   fwd_opnd_k;
	word_t                   ex_result;
	word_t [NUM_FWD_SRC-1:0] fwd_src;

	assign issue_fire = issue_valid_i & issue_ready_o;

	// same source vector feeds both operands
	assign fwd_src[FWD_M1] = m1_result;
	assign fwd_src[FWD_M2] = m2_result;
	assign fwd_src[FWD_WB] = wb_result;

	reg_file u_reg_file (
		.clk         (clk),
		.rst_n       (rst_n),
		.rd_addr_j_i (issue_inst_i.rj),
		.rd_addr_k_i (issue_inst_i.rk),
		.rd_data_j_o (rf_data_j),
		.rd_data_k_o (rf_data_k),
		.wr_en_i     (reg_w_valid_o),
		.wr_addr_i   (reg_w_addr_o),
		.wr_data_i   (reg_w_data_o)
	);

	hazard_fwd u_hazard_fwd (
		.issue_inst_i (issue_inst_i),
		.ex_ctrl_i    (ex_ctrl),
		.m1_ctrl_i    (m1_ctrl),
		.m2_ctrl_i    (m2_ctrl),
		.fwd_j_o      (issue_fwd_j),
		.fwd_k_o      (issue_fwd_k)
	);

	forward_mux #(.SRC_NUM(NUM_FWD_SRC)) u_fwd_j (
		.sel_i  (ex_ctrl.fwd_j),
		.src_i  (fwd_src),
		.held_i (ex_data.opnd_j),
		.data_o (fwd_opnd_j)
	);

	forward_mux #(.SRC_NUM(NUM_FWD_SRC)) u_fwd_k (
		.sel_i  (ex_ctrl.fwd_k),
		.src_i  (fwd_src),
		.held_i (ex_data.opnd_k),
		.data_o (fwd_opnd_k)
	);

	alu u_alu (
		.op_i      (ex_ctrl.alu_op),
		.opnd_j_i  (fwd_opnd_j),
		.opnd_k_i  (fwd_opnd_k),
		.use_imm_i (ex_ctrl.use_imm),
		.imm_i     (ex_data.opnd_k[11:0]),   // immediate kept in the k slot
		.result_o  (ex_result)
	);

	stage_regs u_stage_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.stage_hold_i   (stage_hold_i),
		.issue_fire_i   (issue_fire),
		.issue_inst_i   (issue_inst_i),
		.issue_fwd_j_i  (issue_fwd_j),
		.issue_fwd_k_i  (issue_fwd_k),
		.issue_opnd_j_i (rf_data_j),
		.issue_opnd_k_i (rf_data_k),
		.ex_fwd_j_i     (fwd_opnd_j),
		.ex_fwd_k_i     (fwd_opnd_k),
		.ex_result_i    (ex_result),
		.issue_ready_o  (issue_ready_o),
		.ex_ctrl_o      (ex_ctrl),
		.m1_ctrl_o      (m1_ctrl),
		.m2_ctrl_o      (m2_ctrl),
		.wb_ctrl_o      (wb_ctrl),
		.ex_data_o      (ex_data),
		.m1_result_o    (m1_result),
		.m2_result_o    (m2_result),
		.wb_result_o    (wb_result)
	);

	assign reg_w_valid_o = wb_ctrl.valid;
	assign reg_w_addr_o  = wb_ctrl.rd;
	assign reg_w_data_o  = wb_result;

endmodule

// File: dv/backend_chk.sv
`timescale 1ns/10ps

module backend_chk import backend_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic       issue_ready_i,
	input stall_vec_t stage_hold_i,
	input logic       wb_valid_i,
	input reg_idx_t   wb_addr_i,
	input word_t      wb_data_i
);

	// WB stays clear through reset and the first cycle after it
	a_wb_quiet_reset: assert property (@(posedge clk)
		(!rst_n || $past(!rst_n)) |=> !wb_valid_i)
		else $error("reg_w_valid_o high during or right after reset");

	a_hold_blocks_issue: assert property (@(posedge clk) disable iff (!rst_n)
		(|stage_hold_i) |-> !issue_ready_i)
		else $error("issue_ready_o high while a stage holds");

	a_wb_addr_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid_i |-> (wb_addr_i != '0))
		else $error("writeback to r0");

	a_wb_data_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid_i |-> !$isunknown(wb_data_i))
		else $error("writeback data has unknown bits");

endmodule

bind backend_pipeline backend_chk u_chk (
	.clk           (clk),
	.rst_n         (rst_n),
	.issue_ready_i (issue_ready_o),
	.stage_hold_i  (stage_hold_i),
	.wb_valid_i    (reg_w_valid_o),
	.wb_addr_i     (reg_w_addr_o),
	.wb_data_i     (reg_w_data_o)
);

// File: dv/backend_tb.sv
`timescale 1ns/10ps

module backend_tb import backend_pkg::*; ();

	localparam int          TBL_LEN       = 21;
	localparam int          ISSUE_TIMEOUT = 200;
	localparam int          DRAIN_TIMEOUT = 400;
	localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

	logic       clk;
	logic       rst_n;
	logic       issue_valid;
	inst_t      issue_inst;
	logic       issue_ready;
	stall_vec_t stage_hold;
	logic       reg_w_valid;
	reg_idx_t   reg_w_addr;
	word_t      reg_w_data;

	inst_t       tbl [TBL_LEN];
	word_t       model_regs [NUM_REGS];
	reg_idx_t    exp_addr [$];
	word_t       exp_data [$];
	int          exp_acc [$];   // acceptance edge of each expected write
	logic [31:0] lfsr_state;
	int          cyc;
	bit          check_latency;

	backend_pipeline dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid),
		.issue_inst_i  (issue_inst),
		.issue_ready_o (issue_ready),
		.stage_hold_i  (stage_hold),
		.reg_w_valid_o (reg_w_valid),
		.reg_w_addr_o  (reg_w_addr),
		.reg_w_data_o  (reg_w_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	initial begin
		cyc = 0;
		forever begin
			@(posedge clk);
			cyc++;
		end
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic timeout_abort(string what);
		$display("timeout at %0t while %s", $time, what);
		abort_run();
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %08h got %08h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_cycles(string name, int exp, int act);
		if (act != exp) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic rand_bit(output logic b);
		b = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	endtask

	// each hold bit set about one cycle in four
	task automatic rand_hold(output stall_vec_t h);
		logic a;
		logic b;
		for (int i = 0; i < 3; i++) begin
			rand_bit(a);
			rand_bit(b);
			h[i] = a & b;
		end
	endtask

	function automatic word_t sext12(imm12_t imm);
		return imm[11] ? {20'hfffff, imm} : {20'h00000, imm};
	endfunction

	function automatic word_t expected_result(inst_t in, word_t a, word_t kval);
		word_t      b;
		logic [4:0] sh;
		b = in.use_imm ? sext12(in.imm) : kval;
		sh = b[4:0];
		case (in.alu_op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return a - b;
			ALU_AND:   return a & b;
			ALU_OR:    return a | b;
			ALU_XOR:   return a ^ b;
			ALU_SLT:   return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			ALU_SLTU:  return {31'b0, a < b};
			ALU_SLL:   return a << sh;
			ALU_SRL:   return a >> sh;
			ALU_SRA:   return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
			ALU_LU12I: return {in.imm, 20'h0};
			default:   return '0;
		endcase
	endfunction

	// sequential model, r0 never written
	task automatic model_accept(inst_t in);
		word_t r;
		r = expected_result(in, model_regs[in.rj], model_regs[in.rk]);
		if (in.rd != 5'd0) begin
			model_regs[in.rd] = r;
			exp_addr.push_back(in.rd);
			exp_data.push_back(r);
			exp_acc.push_back(cyc);
		end
	endtask

	function automatic inst_t make_inst(alu_op_e op, reg_idx_t rd, reg_idx_t rj,
		reg_idx_t rk, imm12_t imm, logic use_imm);
		inst_t in;
		in.alu_op  = op;
		in.rd      = rd;
		in.rj      = rj;
		in.rk      = rk;
		in.imm     = imm;
		in.use_imm = use_imm;
		return in;
	endfunction

	task automatic build_table();
		tbl[0]  = make_inst(ALU_ADD,   5'd1,  5'd0,  5'd0,  12'h123, 1'b1);
		tbl[1]  = make_inst(ALU_LU12I, 5'd2,  5'd0,  5'd0,  12'h8f0, 1'b1);
		tbl[2]  = make_inst(ALU_ADD,   5'd3,  5'd1,  5'd2,  12'h000, 1'b0);   // dist 2 and 1
		tbl[3]  = make_inst(ALU_SUB,   5'd4,  5'd3,  5'd1,  12'h000, 1'b0);   // dist 1 and 3
		tbl[4]  = make_inst(ALU_ADD,   5'd5,  5'd0,  5'd0,  12'hffb, 1'b1);   // minus five
		tbl[5]  = make_inst(ALU_AND,   5'd6,  5'd3,  5'd5,  12'h000, 1'b0);
		tbl[6]  = make_inst(ALU_OR,    5'd7,  5'd4,  5'd2,  12'h000, 1'b0);
		tbl[7]  = make_inst(ALU_XOR,   5'd8,  5'd7,  5'd0,  12'h7ff, 1'b1);
		tbl[8]  = make_inst(ALU_SLT,   5'd9,  5'd5,  5'd1,  12'h000, 1'b0);   // r5 at dist 4
		tbl[9]  = make_inst(ALU_SLTU,  5'd10, 5'd5,  5'd1,  12'h000, 1'b0);
		tbl[10] = make_inst(ALU_SLL,   5'd11, 5'd1,  5'd0,  12'h004, 1'b1);
		tbl[11] = make_inst(ALU_SRL,   5'd12, 5'd2,  5'd11, 12'h000, 1'b0);
		tbl[12] = make_inst(ALU_SRA,   5'd13, 5'd2,  5'd0,  12'h008, 1'b1);
		tbl[13] = make_inst(ALU_ADD,   5'd0,  5'd1,  5'd1,  12'h000, 1'b0);   // dropped write
		tbl[14] = make_inst(ALU_ADD,   5'd14, 5'd0,  5'd13, 12'h000, 1'b0);
		tbl[15] = make_inst(ALU_SLT,   5'd15, 5'd5,  5'd0,  12'hfff, 1'b1);
		tbl[16] = make_inst(ALU_SLTU,  5'd16, 5'd1,  5'd0,  12'hfff, 1'b1);
		tbl[17] = make_inst(ALU_ADD,   5'd17, 5'd14, 5'd14, 12'h000, 1'b0);
		tbl[18] = make_inst(ALU_SUB,   5'd18, 5'd17, 5'd0,  12'h001, 1'b1);
		tbl[19] = make_inst(ALU_XOR,   5'd1,  5'd18, 5'd17, 12'h000, 1'b0);
		tbl[20] = make_inst(ALU_AND,   5'd20, 5'd1,  5'd0,  12'h0f0, 1'b1);
	endtask

	// entered and left 1 ns after a rising edge
	task automatic issue_one(inst_t in, bit with_holds);
		logic       rdy;
		stall_vec_t h;
		int         waited;
		issue_valid = 1'b1;
		issue_inst = in;
		waited = 0;
		rdy = 1'b0;
		while (!rdy) begin
			h = '0;
			if (with_holds) begin
				rand_hold(h);
			end
			stage_hold = h;
			#1;
			check_bit("issue_ready_o", !(|h), issue_ready);
			rdy = issue_ready;   // ready only follows the holds
			@(posedge clk);
			#1;
			waited++;
			if (!rdy && waited > ISSUE_TIMEOUT) begin
				timeout_abort("waiting for issue_ready_o");
			end
		end
		model_accept(in);
	endtask

	task automatic drain(bit with_holds);
		stall_vec_t h;
		int         waited;
		issue_valid = 1'b0;
		waited = 0;
		while (exp_addr.size() != 0) begin
			h = '0;
			if (with_holds) begin
				rand_hold(h);
			end
			stage_hold = h;
			@(posedge clk);
			#1;
			waited++;
			if (waited > DRAIN_TIMEOUT) begin
				timeout_abort("waiting for the expected writebacks");
			end
		end
		stage_hold = '0;
		repeat (6) @(posedge clk);   // room for a stray extra write
		#1;
	endtask

	// writeback monitor, outputs are registered so +2 ns is stable
	initial begin
		reg_idx_t ea;
		word_t    ed;
		int       acc;
		forever begin
			@(posedge clk);
			#2;
			if (rst_n && reg_w_valid) begin
				if (exp_addr.size() == 0) begin
					$display("writeback to r%0d at %0t with no write expected", reg_w_addr, $time);
					abort_run();
				end else begin
					ea = exp_addr.pop_front();
					ed = exp_data.pop_front();
					acc = exp_acc.pop_front();
					check_idx("reg_w_addr_o", ea, reg_w_addr);
					check_word("reg_w_data_o", ed, reg_w_data);
					if (check_latency) begin
						check_cycles("reg_w_valid_o cycle after accept", 4, cyc - acc + 1);
					end
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_inst = '0;
		stage_hold = '0;
		lfsr_state = 32'd72793;
		check_latency = 1'b0;
		build_table();
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// idle pipe after reset
		repeat (4) begin
			@(posedge clk);
			#1;
			check_bit("issue_ready_o", 1'b1, issue_ready);
			check_bit("reg_w_valid_o", 1'b0, reg_w_valid);
		end
		check_latency = 1'b1;
		for (int i = 0; i < TBL_LEN; i++) begin
			issue_one(tbl[i], 1'b0);
		end
		drain(1'b0);
		check_latency = 1'b0;
		// same table again, random stalls on top
		for (int i = 0; i < TBL_LEN; i++) begin
			issue_one(tbl[i], 1'b1);
		end
		drain(1'b1);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: verilog.f
hw/backend_pkg.sv
hw/reg_file.sv
hw/hazard_fwd.sv
hw/forward_mux.sv
hw/stage_regs.sv
hw/alu.sv
hw/backend_pipeline.sv
dv/backend_chk.sv
dv/backend_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module backend_tb -Mdir obj_dir -o sim_backend

out=$(./obj_dir/sim_backend 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "PASS: all tests"; then
	exit 0
fi
exit 1
